/* vlog.f */
src/cic_pkg.sv
src/cic_rate_control.sv
src/cic_integrator_chain.sv
src/cic_comb_chain.sv
src/cic_decimator.sv
verif/cic_decimator_checker.sv
verif/cic_decimator_tb.sv

/* Bender.yml */
package:
  name: cic_decimator

sources:
  # design, package first
  - src/cic_pkg.sv
  - src/cic_rate_control.sv
  - src/cic_integrator_chain.sv
  - src/cic_comb_chain.sv
  - src/cic_decimator.sv

  # verification
  - target: test
    files:
      - verif/cic_decimator_checker.sv
      - verif/cic_decimator_tb.sv

# top modules: cic_decimator (RTL), cic_decimator_tb (testbench)
# compile order matches vlog.f

/* verif/cic_decimator_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_decimator_tb;

	import cic_pkg::*;

	logic        clock;
	logic        reset;
	rate_cfg_t   cfg;
	cic_sample_t sample_in;
	cic_sample_t sample_out;

	logic [31:0]                 rng_state;       // lcg state, stimulus process only
	logic signed [out_width-1:0] expected_value;  // settled output of a constant run
	logic                        check_enable;    // monitor compares output values
	int                          out_count;       // outputs since the last rate write
	int                          value_errors = 0;
	int                          count_errors = 0;
	int                          timeouts = 0;
	int                          total_errors;

	cic_decimator i_dut (
		.clock      (clock),
		.reset      (reset),
		.cfg        (cfg),
		.sample_in  (sample_in),
		.sample_out (sample_out)
	);

	bind cic_decimator cic_decimator_checker i_checker (
		.clock      (clock),
		.reset      (reset),
		.cfg        (cfg),
		.sample_in  (sample_in),
		.sample_out (sample_out)
	);

	always #20 clock = ~clock;   // 40 ns period

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	// let anything in flight leave the pipeline, then write the code for one cycle
	task automatic write_rate(input rate_log2_t code);
		idle_cycles(stages + 6);
		@(posedge clock);
		cfg.valid     <= 1'b1;
		cfg.rate_log2 <= code;
		@(posedge clock);
		cfg.valid     <= 1'b0;
	endtask

	// valid samples with 1 .. 4 idle cycles in front of each
	// at rate 1 every input makes an output, so inputs never come back to back
	task automatic send_samples(input int count, input logic signed [in_width-1:0] value,
			input bit random_data);
		int n;
		int g;
		int gap;
		for (n = 0; n < count; n++)
		begin
			rng_state = lcg_next(rng_state);
			gap = int'(rng_state[31:30]) + 1;
			for (g = 0; g < gap; g++)
			begin
				@(posedge clock);
				sample_in.valid <= 1'b0;
			end
			@(posedge clock);
			sample_in.valid <= 1'b1;
			sample_in.data  <= random_data ? rng_state[23:8] : value;
		end
		@(posedge clock);
		sample_in.valid <= 1'b0;
	endtask

	task automatic wait_outputs(input int target);
		int cycles;
		cycles = 0;
		while (out_count < target && cycles < 64)
		begin
			@(posedge clock);
			cycles++;
		end
		if (out_count < target)
		begin
			$display("timeout: output %0d did not arrive within 64 cycles, %0d seen",
				target, out_count);
			timeouts++;
		end
	endtask

	task automatic expect_outputs(input int expected, input string what);
		assert (out_count == expected)
		else
		begin
			$display("[ERROR] %0t: %s gave %0d outputs, expected %0d",
				$time, what, out_count, expected);
			count_errors++;
		end
	endtask

	// constant input after a write, outputs past the transient must equal x
	task automatic run_constant(input rate_log2_t code, input logic signed [in_width-1:0] x);
		int rate;
		rate = 1 << code;
		expected_value = x;
		write_rate(code);
		check_enable = 1'b1;
		send_samples((stages + 4) * rate, x, 1'b0);
		wait_outputs(stages + 4);
		check_enable = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// output monitor
	// ------------------------------------------------------------------------

	always @(posedge clock)
	begin
		if (reset || cfg.valid)
			out_count <= 0;                     // counting restarts with the write
		else if (sample_out.valid)
		begin
			if (check_enable && out_count >= stages + 1)
			begin
				assert (sample_out.data == expected_value)
				else
				begin
					$display("[ERROR] %0t: output %0d is %0d, expected %0d",
						$time, out_count + 1, sample_out.data, expected_value);
					value_errors++;
				end
			end
			out_count <= out_count + 1;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	initial
	begin : stimulus
		rate_log2_t                 codes [3];
		logic signed [in_width-1:0] levels [3];
		int                         c;
		int                         l;
		clock          = 1'b0;
		reset          = 1'b1;
		cfg            = '0;
		sample_in      = '0;
		rng_state      = 32'hcee0_76fd;
		check_enable   = 1'b0;
		expected_value = '0;
		codes  = '{4'd0, 4'd3, 4'd8};
		levels = '{16'sd12345, -16'sd20000, -16'sd32768};
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		// reset code is 8, random data
		send_samples(256 + 40, '0, 1'b1);
		wait_outputs(1);
		idle_cycles(stages + 6);
		expect_outputs(1, "first group at the reset rate");

		for (c = 0; c < 3; c++)
			for (l = 0; l < 3; l++)
				run_constant(codes[c], levels[l]);

		// code 12 clamps to 8
		write_rate(4'd12);
		send_samples(2 * 256 + 100, '0, 1'b1);
		wait_outputs(2);
		idle_cycles(stages + 6);
		expect_outputs(2, "clamped code 12");

		// write in the middle of a group drops the partial group
		write_rate(4'd3);
		send_samples(5, '0, 1'b1);
		write_rate(4'd3);
		send_samples(7, '0, 1'b1);
		idle_cycles(stages + 6);
		expect_outputs(0, "seven samples after a flush");
		send_samples(1, '0, 1'b1);
		wait_outputs(1);
		idle_cycles(stages + 6);
		expect_outputs(1, "eight samples after a flush");

		total_errors = value_errors + count_errors + timeouts + i_dut.i_checker.failures;
		$display("value errors %0d, count errors %0d, timeouts %0d, assertion failures %0d",
			value_errors, count_errors, timeouts, i_dut.i_checker.failures);
		if (total_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// hard stop if the stimulus never gets to the end
	initial
	begin : watchdog
		repeat (200000) @(posedge clock);
		$display("run limit of 200000 cycles reached before the stimulus finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/cic_decimator_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_decimator_checker (
	input wire                       clock,
	input wire                       reset,
	input wire cic_pkg::rate_cfg_t   cfg,
	input wire cic_pkg::cic_sample_t sample_in,
	input wire cic_pkg::cic_sample_t sample_out
);

	import cic_pkg::*;

	rate_log2_t  code;        // clamped code, own copy
	int unsigned in_total;    // input valids since the last write or reset
	int unsigned out_total;   // output valids since the last write or reset
	int unsigned rate_mask;   // rate minus one
	logic        group_done;  // some group has completed since reset
	logic        completes;   // the input in this cycle closes a group

	int idle_failures = 0;
	int gap_failures = 0;
	int count_failures = 0;
	int latency_failures = 0;
	int origin_failures = 0;
	int failures;             // read by the testbench

	assign failures = idle_failures + gap_failures + count_failures
		+ latency_failures + origin_failures;

	// ------------------------------------------------------------------------
	// reference counters
	// ------------------------------------------------------------------------

	assign rate_mask = (32'd1 << code) - 1;
	assign completes = sample_in.valid && !cfg.valid && (((in_total + 1) & rate_mask) == 0);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			code       <= rate_log2_t'(max_rate_log2);
			in_total   <= 0;
			out_total  <= 0;
			group_done <= 1'b0;
		end
		else if (cfg.valid)
		begin
			code      <= (cfg.rate_log2 > max_rate_log2) ? rate_log2_t'(max_rate_log2)
				: cfg.rate_log2;
			in_total  <= 0;                     // sample in the write cycle is dropped
			out_total <= 0;
		end
		else
		begin
			if (sample_in.valid)
				in_total <= in_total + 1;
			if (sample_out.valid)
				out_total <= out_total + 1;
			if (completes)
				group_done <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------------------

	idle_until_first_group : assert property (@(posedge clock) disable iff (reset)
		!group_done |-> (sample_out == '0))
	else
	begin
		$error("output not idle before the first group completed");
		idle_failures++;
	end

	single_cycle_valid : assert property (@(posedge clock) disable iff (reset)
		sample_out.valid |=> !sample_out.valid)
	else
	begin
		$error("sample_out.valid high in two consecutive cycles");
		gap_failures++;
	end

	// count as it stood when the completing input went in
	output_count : assert property (@(posedge clock) disable iff (reset)
		sample_out.valid |-> (out_total + 1 == ($past(in_total, stages + 3) >> code)))
	else
	begin
		$error("output count does not match input count over the rate");
		count_failures++;
	end

	output_latency : assert property (@(posedge clock) disable iff (reset)
		completes |-> ##(stages + 4) sample_out.valid)
	else
	begin
		$error("no output at the fixed latency after a completed group");
		latency_failures++;
	end

	output_origin : assert property (@(posedge clock) disable iff (reset)
		sample_out.valid |-> $past(completes, stages + 4))
	else
	begin
		$error("output without a completed group at the fixed latency");
		origin_failures++;
	end

endmodule

`default_nettype wire

/* src/cic_decimator.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_decimator (
	input  wire                          clock,
	input  wire                          reset,
	input  wire cic_pkg::rate_cfg_t      cfg,
	input  wire cic_pkg::cic_sample_t    sample_in,
	output cic_pkg::cic_sample_t         sample_out
);

	import cic_pkg::*;

	logic                   flush;       // one cycle after a rate write
	logic [shift_width-1:0] shift;       // pre-shift for the current code
	logic                   dec_strobe;  // group of rate samples complete
	acc_stream_t            integ_out;   // decimated full width sum

	// ------------------------------------------------------------------------
	// rate register, counter and flush
	// ------------------------------------------------------------------------

	cic_rate_control i_rate_control (
		.clock      (clock),
		.reset      (reset),
		.cfg        (cfg),
		.in_valid   (sample_in.valid),
		.flush      (flush),
		.shift      (shift),
		.dec_strobe (dec_strobe)
	);

	// input rate section
	cic_integrator_chain i_integrator_chain (
		.clock      (clock),
		.reset      (reset),
		.flush      (flush),
		.shift      (shift),
		.dec_strobe (dec_strobe),
		.sample_in  (sample_in),
		.integ_out  (integ_out)
	);

	// decimated section, stages + 4 cycles after the completing input
	cic_comb_chain i_comb_chain (
		.clock      (clock),
		.reset      (reset),
		.flush      (flush),
		.integ_out  (integ_out),
		.sample_out (sample_out)
	);

endmodule

`default_nettype wire

/* src/cic_comb_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_comb_chain (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          flush,
	input  wire cic_pkg::acc_stream_t    integ_out,
	output cic_pkg::cic_sample_t         sample_out
);

	import cic_pkg::*;

	acc_stream_t                 in_reg;      // captured decimated sum
	acc_t                        comb_out;    // last comb result
	logic                        comb_valid;  // comb_out just updated
	logic signed [out_width-1:0] rounded;     // top bits plus rounding bit

	// ------------------------------------------------------------------------
	// input capture
	// ------------------------------------------------------------------------

	always_ff @(posedge clock)
	begin
		if (reset || flush)
			in_reg <= '0;
		else
			in_reg <= integ_out;
	end

	// ------------------------------------------------------------------------
	// combs
	// ------------------------------------------------------------------------

	// differences ripple through in one cycle, all delay registers load together
	for (genvar i = 0; i < stages; i++)
	begin : g_comb
		acc_t comb_in;   // input of this comb
		acc_t prev;      // input seen at the previous decimated strobe
		acc_t diff;      // comb result

		if (i == 0)
		begin : g_first
			assign comb_in = in_reg.data;
		end
		else
		begin : g_next
			assign comb_in = g_comb[i-1].diff;
		end

		assign diff = comb_in - prev;

		always_ff @(posedge clock)
		begin
			if (reset || flush)
				prev <= '0;
			else if (in_reg.valid)
				prev <= comb_in;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			comb_out   <= '0;
			comb_valid <= 1'b0;
		end
		else
		begin
			comb_valid <= in_reg.valid;
			if (in_reg.valid)
				comb_out <= g_comb[stages-1].diff;
		end
	end

	// ------------------------------------------------------------------------
	// rounding and output register
	// ------------------------------------------------------------------------

	// round half up on the first dropped bit
	assign rounded = comb_out[acc_width-1 -: out_width]
		+ out_width'(comb_out[acc_width-out_width-1]);

	always_ff @(posedge clock)
	begin
		if (reset || flush)
			sample_out <= '0;
		else
		begin
			sample_out.valid <= comb_valid;         // single cycle per output
			if (comb_valid)
				sample_out.data <= rounded;         // data holds between outputs
		end
	end

endmodule

`default_nettype wire

/* src/cic_integrator_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_integrator_chain (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              flush,
	input  wire [cic_pkg::shift_width-1:0]   shift,
	input  wire                              dec_strobe,
	input  wire cic_pkg::cic_sample_t        sample_in,
	output cic_pkg::acc_stream_t             integ_out
);

	import cic_pkg::*;

	acc_t              wide_in;      // sign extended input sample
	acc_t              pre_data;     // pre-shifted sample, first integrator input
	logic [stages-1:0] stage_valid;  // bit i enables integrator i
	logic [stages-1:0] dec_pipe;     // decimation strobe, delayed with the data

	// ------------------------------------------------------------------------
	// pre-shift
	// ------------------------------------------------------------------------

	assign wide_in = acc_t'(signed'(sample_in.data));

	always_ff @(posedge clock)
	begin
		if (reset)
			pre_data <= '0;
		else if (sample_in.valid)
			pre_data <= wide_in <<< shift;   // shift already follows the new code
		else if (flush)
			pre_data <= '0;
	end

	// valid pipeline, a stage advances only when a real sample reaches it
	always_ff @(posedge clock)
	begin
		if (reset)
			stage_valid <= '0;
		else if (flush)
			stage_valid <= {{(stages - 1){1'b0}}, sample_in.valid};
		else
			stage_valid <= {stage_valid[stages-2:0], sample_in.valid};
	end

	// ------------------------------------------------------------------------
	// integrators
	// ------------------------------------------------------------------------

	for (genvar i = 0; i < stages; i++)
	begin : g_integ
		acc_t addend;   // previous stage sum, or the pre-shift register
		acc_t sum;      // running sum, wraps modulo 2**acc_width

		if (i == 0)
		begin : g_first
			assign addend = pre_data;
		end
		else
		begin : g_next
			assign addend = g_integ[i-1].sum;
		end

		always_ff @(posedge clock)
		begin
			if (reset || flush)
				sum <= '0;
			else if (stage_valid[i])
				sum <= sum + addend;
		end
	end

	// strobe comes one cycle after the last input, the sum needs stages more
	always_ff @(posedge clock)
	begin
		if (reset || flush)
			dec_pipe <= '0;
		else
			dec_pipe <= {dec_pipe[stages-2:0], dec_strobe};
	end

	assign integ_out.valid = dec_pipe[stages-1];
	assign integ_out.data  = g_integ[stages-1].sum;

endmodule

`default_nettype wire

/* src/cic_rate_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cic_rate_control (
	input  wire                              clock,
	input  wire                              reset,
	input  wire cic_pkg::rate_cfg_t          cfg,
	input  wire                              in_valid,
	output logic                             flush,
	output logic [cic_pkg::shift_width-1:0]  shift,
	output logic                             dec_strobe
);

	import cic_pkg::*;

	rate_log2_t rate_log2;                  // clamped code in use
	rate_log2_t cfg_clamped;                // code on the port, limited to the max
	logic [count_width-1:0] count;          // input valids in the current group
	logic [count_width:0]   rate_value;     // 2**rate_log2, one bit wider for 256
	logic [count_width-1:0] last_count;     // count value of the last sample in a group

	// ------------------------------------------------------------------------
	// rate register
	// ------------------------------------------------------------------------

	// codes above the max behave as the max
	assign cfg_clamped = (cfg.rate_log2 > max_rate_log2) ?
		rate_log2_t'(max_rate_log2) : cfg.rate_log2;

	always_ff @(posedge clock)
	begin
		if (reset)
			rate_log2 <= rate_log2_t'(max_rate_log2);   // slowest rate out of reset
		else if (cfg.valid)
			rate_log2 <= cfg_clamped;
	end

	// flush the datapath in the cycle after a write
	always_ff @(posedge clock)
	begin
		if (reset)
			flush <= 1'b0;
		else
			flush <= cfg.valid;
	end

	// gain normalization
	// chain gain is 2**(stages*k), so the pre-shift makes up the rest of growth
	assign shift = shift_width'(growth - stages * rate_log2);

	// ------------------------------------------------------------------------
	// sample counter
	// ------------------------------------------------------------------------

	assign rate_value = (count_width + 1)'(1) << rate_log2;
	assign last_count = count_width'(rate_value - 1'b1);    // 255 at code 8, 0 at code 0

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count      <= '0;
			dec_strobe <= 1'b0;
		end
		else if (cfg.valid)
		begin
			// a write restarts the group, a sample in this cycle is dropped
			count      <= '0;
			dec_strobe <= 1'b0;
		end
		else if (in_valid)
		begin
			if (count == last_count)
			begin
				count      <= '0;
				dec_strobe <= 1'b1;     // group complete
			end
			else
			begin
				count      <= count + 1'b1;
				dec_strobe <= 1'b0;
			end
		end
		else
			dec_strobe <= 1'b0;         // one cycle wide
	end

endmodule

`default_nettype wire

/* src/cic_pkg.sv */
`default_nettype none

package cic_pkg;

	// ------------------------------------------------------------------------
	// widths and rate limits
	// ------------------------------------------------------------------------

	localparam int in_width        = 16;                        // input sample width
	localparam int out_width       = 16;                        // output sample width
	localparam int stages          = 4;                         // integrators, and combs
	localparam int max_rate_log2   = 8;                         // rate 256 at most
	localparam int growth          = stages * max_rate_log2;    // worst case bit growth
	localparam int acc_width       = in_width + growth;         // full precision, no pruning
	localparam int count_width     = max_rate_log2;             // counts 0 .. 255
	localparam int rate_code_width = 4;                         // codes 0 .. 15 on the port
	localparam int shift_width     = 6;                         // holds 0 .. growth

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------

	typedef logic [rate_code_width-1:0] rate_log2_t;            // log2 of the rate

	typedef logic signed [acc_width-1:0] acc_t;                 // accumulator word

	// one sample on the input or the output stream
	// in_width and out_width are the same, so one type serves both sides
	typedef struct packed {
		logic                       valid;
		logic signed [in_width-1:0] data;
	} cic_sample_t;

	// rate write, valid for a single cycle
	typedef struct packed {
		logic       valid;
		rate_log2_t rate_log2;
	} rate_cfg_t;

	// full width value from the integrators into the combs
	typedef struct packed {
		logic valid;
		acc_t data;
	} acc_stream_t;

endpackage

`default_nettype wire
